// File: fetch_btb.f
+incdir+include
hw/btb_pkg.sv
hw/btb_bank.sv
hw/btb_commit_stage.sv
hw/btb_hit_check.sv
hw/btb_next_pc.sv
hw/fetch_btb.sv
sim/fetch_btb_tb.sv

// File: Makefile
# Verilator build and run of the fetch_btb testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := fetch_btb_tb
FILELIST  := fetch_btb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/fetch_btb_tb.sv
// btb testbench with stimulus table, reference model, check task and cycle timeout
`timescale 1ns/1ps
`default_nettype none

`include "btb_cfg.svh"

module fetch_btb_tb
  import btb_pkg::*;
();

  localparam int          CLK_PERIOD     = 40;
  localparam int          DRIVE_DLY      = 2;      // inputs change this long after posedge
  localparam int          RST_CYCLES     = 16;
  localparam int          N_ROWS         = 12;
  localparam int          CYCLES_PER_ROW = 6;      // commit, two idle, three held
  localparam int          TIMEOUT_CYCLES = N_ROWS * CYCLES_PER_ROW + RST_CYCLES + 20;
  localparam logic [31:0] SEED           = 32'he99a8186;

  // one table row with commit group, lookup inputs and expected result
  typedef struct packed {
    pc_addr_t [3:0] c_pc;
    pc_addr_t [3:0] c_tgt;
    logic [3:0]     c_takb;
    pc_addr_t       fetch;
    logic           miss;
    pc_addr_t       miss_pc;
    logic           call;
    pc_addr_t       call_tgt;
    pc_addr_t       exp_pc;
    logic           exp_takb;
    logic           exp_hit;     // hit_slot only checked on a model hit
    slot_t          exp_slot;
  } row_t;

  // dut signals
  logic       clk;
  logic       rst;
  pc_addr_t   fetch_pc;
  logic       miss_redirect;
  pc_addr_t   miss_pc;
  logic       call_redirect;
  pc_addr_t   call_tgt;
  pc_addr_t   commit_pc  [4];
  pc_addr_t   commit_tgt [4];
  logic [3:0] commit_takb;
  pc_addr_t   next_pc;
  logic       takb;
  slot_t      hit_slot;

  row_t        rows     [N_ROWS];
  string       row_name [N_ROWS];
  row_t        cur;                 // row under construction
  int          n_rows      = 0;
  int          err_count   = 0;
  int          pass_rows   = 0;
  int          fail_rows   = 0;
  int          cycle_count = 0;
  logic [31:0] rng_state;

  // reference btb with one table per slot
  logic     m_takb [`BTB_SLOTS][`BTB_DEPTH];
  pc_addr_t m_pc   [`BTB_SLOTS][`BTB_DEPTH];
  pc_addr_t m_tgt  [`BTB_SLOTS][`BTB_DEPTH];

  fetch_btb i_fetch_btb (
    .clk           (clk),
    .rst           (rst),
    .fetch_pc      (fetch_pc),
    .miss_redirect (miss_redirect),
    .miss_pc       (miss_pc),
    .call_redirect (call_redirect),
    .call_tgt      (call_tgt),
    .commit_pc0    (commit_pc[0]),
    .commit_pc1    (commit_pc[1]),
    .commit_pc2    (commit_pc[2]),
    .commit_pc3    (commit_pc[3]),
    .commit_tgt0   (commit_tgt[0]),
    .commit_tgt1   (commit_tgt[1]),
    .commit_tgt2   (commit_tgt[2]),
    .commit_tgt3   (commit_tgt[3]),
    .commit_takb0  (commit_takb[0]),
    .commit_takb1  (commit_takb[1]),
    .commit_takb2  (commit_takb[2]),
    .commit_takb3  (commit_takb[3]),
    .next_pc       (next_pc),
    .takb          (takb),
    .hit_slot      (hit_slot)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // hard stop if the row loop stalls
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  // ==============================
  // random numbers and reference model
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v         = rng_state;
  endtask

  // bank row from the index field of the address
  function automatic btb_idx_t row_of(input pc_addr_t pc);
    return pc[`BTB_IDX_LO +: `BTB_IDX_W];
  endfunction

  // whole row written at slot 0's index only when some slot is taken
  task automatic model_commit(input row_t r);
    btb_idx_t idx;
    int       k;
    idx = row_of(r.c_pc[0]);
    if (|r.c_takb) begin
      for (k = 0; k < `BTB_SLOTS; k++) begin
        m_takb[k][idx] = r.c_takb[k];
        m_pc[k][idx]   = r.c_pc[k];
        m_tgt[k][idx]  = r.c_tgt[k];
      end
    end
  endtask

  // miss, then call, then lowest taken hit, then fetch + 20
  task automatic model_lookup(inout row_t r);
    btb_idx_t idx;
    pc_addr_t slot_pc;
    pc_addr_t tgt;
    logic     found;
    int       k;
    idx        = row_of(r.fetch);
    found      = 1'b0;
    tgt        = '0;
    r.exp_slot = slot_t'(0);
    for (k = 0; k < `BTB_SLOTS; k++) begin
      slot_pc = r.fetch + pc_addr_t'(k * `BTB_INSN_BYTES);
      if (!found && m_takb[k][idx] && (m_pc[k][idx] == slot_pc)) begin
        found      = 1'b1;
        tgt        = m_tgt[k][idx];
        r.exp_slot = slot_t'(k);
      end
    end
    r.exp_hit  = found;
    r.exp_takb = r.miss | r.call | found;
    if (r.miss)       r.exp_pc = r.miss_pc;
    else if (r.call)  r.exp_pc = r.call_tgt;
    else if (found)   r.exp_pc = tgt;
    else              r.exp_pc = r.fetch + pc_addr_t'(`BTB_FETCH_BYTES);
  endtask

  // ==============================
  // table construction
  // ==============================
  // four sequential slots from base, random targets, taken bits from mask
  task automatic fill_commit(input pc_addr_t base, input logic [3:0] mask);
    logic [31:0] r;
    int          k;
    for (k = 0; k < `BTB_SLOTS; k++) begin
      next_rand(r);
      cur.c_pc[k]   = base + pc_addr_t'(k * `BTB_INSN_BYTES);
      cur.c_tgt[k]  = r;
      cur.c_takb[k] = mask[k];
    end
  endtask

  task automatic push_row(input string name);
    if (n_rows >= N_ROWS) begin
      $display("table overflow: row %s does not fit", name);
      err_count++;
    end else begin
      model_commit(cur);
      model_lookup(cur);
      rows[n_rows]     = cur;
      row_name[n_rows] = name;
      n_rows++;
    end
    cur = '0;
  endtask

  task automatic build_table();
    logic [31:0] r;
    pc_addr_t    a;
    pc_addr_t    a2;
    pc_addr_t    b;
    pc_addr_t    c;
    next_rand(r);
    a  = r;
    a2 = a ^ 32'h0040_0000;             // flip bit 22 for the same row as a with a new tag
    b  = a + pc_addr_t'(1 << `BTB_IDX_LO);
    c  = a + pc_addr_t'(2 << `BTB_IDX_LO);
    cur = '0;
    next_rand(r);
    cur.fetch = r;
    push_row("reset_seq_a");
    next_rand(r);
    cur.fetch = r;
    push_row("reset_seq_b");
    fill_commit(a, 4'b0001);
    cur.fetch = a;
    push_row("slot0_taken");
    fill_commit(b, 4'b0100);
    cur.fetch = b;
    push_row("slot2_only");
    fill_commit(c, 4'b0110);
    cur.fetch = c;
    push_row("slot1_over_slot2");
    cur.fetch = a;
    cur.miss  = 1'b1;
    cur.call  = 1'b1;
    next_rand(r);
    cur.miss_pc = r;
    next_rand(r);
    cur.call_tgt = r;
    push_row("miss_over_call");
    cur.fetch = a;
    cur.call  = 1'b1;
    next_rand(r);
    cur.call_tgt = r;
    push_row("call_over_hit");
    cur.fetch = a;
    cur.miss  = 1'b1;
    next_rand(r);
    cur.miss_pc = r;
    push_row("miss_over_hit");
    fill_commit(a2, 4'b0001);
    cur.fetch = a;
    push_row("replace_old_seq");
    cur.fetch = a2;
    push_row("replace_new_hit");
    fill_commit(c, 4'b0000);
    cur.fetch = c;
    push_row("no_taken_no_write");
    next_rand(r);
    cur.fetch = r;
    push_row("random_fetch");
  endtask

  // ==============================
  // apply and check
  // ==============================
  task automatic check_value(input string test, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s %s expected %h actual %h", test, field, exp, act);
      err_count++;
    end
  endtask

  task automatic run_row(input int i);
    int errs_before;
    int k;
    errs_before = err_count;
    @(posedge clk);
    #DRIVE_DLY;
    miss_redirect = 1'b0;               // drop last row's redirects
    call_redirect = 1'b0;
    for (k = 0; k < 4; k++) begin
      commit_pc[k]  = rows[i].c_pc[k];
      commit_tgt[k] = rows[i].c_tgt[k];
    end
    commit_takb = rows[i].c_takb;       // one-cycle commit strobe
    @(posedge clk);
    #DRIVE_DLY;
    commit_takb = 4'b0000;
    @(posedge clk);                     // staged write lands in the banks
    @(posedge clk);
    #DRIVE_DLY;
    fetch_pc      = rows[i].fetch;
    miss_redirect = rows[i].miss;
    miss_pc       = rows[i].miss_pc;
    call_redirect = rows[i].call;
    call_tgt      = rows[i].call_tgt;
    @(posedge clk);                     // read address reg
    @(posedge clk);                     // read data reg
    @(negedge clk);                     // outputs settled by mid third cycle
    check_value(row_name[i], "next_pc", rows[i].exp_pc, next_pc);
    check_value(row_name[i], "takb", 32'(rows[i].exp_takb), 32'(takb));
    if (rows[i].exp_hit)
      check_value(row_name[i], "hit_slot", 32'(rows[i].exp_slot), 32'(hit_slot));
    if (err_count == errs_before) begin
      pass_rows++;
      $display("PASS %0d %s", i, row_name[i]);
    end else begin
      fail_rows++;
      $display("FAIL %0d %s", i, row_name[i]);
    end
  endtask

  initial begin
    rng_state     = SEED;
    rst           = 1'b1;
    fetch_pc      = '0;
    miss_redirect = 1'b0;
    miss_pc       = '0;
    call_redirect = 1'b0;
    call_tgt      = '0;
    commit_takb   = 4'b0000;
    for (int k = 0; k < 4; k++) begin
      commit_pc[k]  = '0;
      commit_tgt[k] = '0;
    end
    for (int s = 0; s < `BTB_SLOTS; s++) begin
      for (int j = 0; j < `BTB_DEPTH; j++) begin
        m_takb[s][j] = 1'b0;            // empty like the banks at power up
        m_pc[s][j]   = '0;
        m_tgt[s][j]  = '0;
      end
    end
    build_table();
    if (n_rows != N_ROWS) begin
      $display("table holds %0d rows instead of %0d", n_rows, N_ROWS);
      err_count++;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++)
      run_row(i);
    $display("rows %0d, passed %0d, failed %0d, errors %0d",
             n_rows, pass_rows, fail_rows, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : fetch_btb_tb

`default_nettype wire

// File: hw/fetch_btb.sv
// btb top level with commit stage, four slot banks, hit check and next-pc control
`timescale 1ns/1ps
`default_nettype none

`include "btb_cfg.svh"

module fetch_btb
  import btb_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  // fetch side
  input  wire pc_addr_t  fetch_pc,
  input  wire            miss_redirect,
  input  wire pc_addr_t  miss_pc,
  input  wire            call_redirect,
  input  wire pc_addr_t  call_tgt,
  // commit side
  input  wire pc_addr_t  commit_pc0,
  input  wire pc_addr_t  commit_pc1,
  input  wire pc_addr_t  commit_pc2,
  input  wire pc_addr_t  commit_pc3,
  input  wire pc_addr_t  commit_tgt0,
  input  wire pc_addr_t  commit_tgt1,
  input  wire pc_addr_t  commit_tgt2,
  input  wire pc_addr_t  commit_tgt3,
  input  wire            commit_takb0,
  input  wire            commit_takb1,
  input  wire            commit_takb2,
  input  wire            commit_takb3,
  // prediction
  output pc_addr_t       next_pc,
  output logic           takb,
  output slot_t          hit_slot         // debug only
);

  // staged write shared by all banks except the per-slot fields
  logic                  wr_en;
  btb_idx_t              wr_idx;
  pc_addr_t              wr_pc   [`BTB_SLOTS];
  pc_addr_t              wr_tgt  [`BTB_SLOTS];
  logic [`BTB_SLOTS-1:0] wr_takb;

  // bank read data
  pc_addr_t              rd_pc   [`BTB_SLOTS];
  pc_addr_t              rd_tgt  [`BTB_SLOTS];
  logic [`BTB_SLOTS-1:0] rd_takb;

  logic                  hit;
  pc_addr_t              hit_tgt;

  // ==============================
  // commit path
  // ==============================
  btb_commit_stage i_commit_stage (
    .clk          (clk),
    .rst          (rst),
    .commit_pc0   (commit_pc0),
    .commit_pc1   (commit_pc1),
    .commit_pc2   (commit_pc2),
    .commit_pc3   (commit_pc3),
    .commit_tgt0  (commit_tgt0),
    .commit_tgt1  (commit_tgt1),
    .commit_tgt2  (commit_tgt2),
    .commit_tgt3  (commit_tgt3),
    .commit_takb0 (commit_takb0),
    .commit_takb1 (commit_takb1),
    .commit_takb2 (commit_takb2),
    .commit_takb3 (commit_takb3),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_pc0       (wr_pc[0]),
    .wr_pc1       (wr_pc[1]),
    .wr_pc2       (wr_pc[2]),
    .wr_pc3       (wr_pc[3]),
    .wr_tgt0      (wr_tgt[0]),
    .wr_tgt1      (wr_tgt[1]),
    .wr_tgt2      (wr_tgt[2]),
    .wr_tgt3      (wr_tgt[3]),
    .wr_takb0     (wr_takb[0]),
    .wr_takb1     (wr_takb[1]),
    .wr_takb2     (wr_takb[2]),
    .wr_takb3     (wr_takb[3])
  );

  // ==============================
  // one bank per slot and all read at the fetch_pc row
  // ==============================
  for (genvar k = 0; k < `BTB_SLOTS; k++) begin : g_bank
    btb_bank i_bank (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .wr_takb (wr_takb[k]),
      .wr_pc   (wr_pc[k]),
      .wr_tgt  (wr_tgt[k]),
      .rd_idx  (fetch_pc[`BTB_IDX_LO +: `BTB_IDX_W]),
      .rd_takb (rd_takb[k]),
      .rd_pc   (rd_pc[k]),
      .rd_tgt  (rd_tgt[k])
    );
  end

  // ==============================
  // lookup and select
  // ==============================
  btb_hit_check i_hit_check (
    .fetch_pc (fetch_pc),
    .rd_takb0 (rd_takb[0]),
    .rd_takb1 (rd_takb[1]),
    .rd_takb2 (rd_takb[2]),
    .rd_takb3 (rd_takb[3]),
    .rd_pc0   (rd_pc[0]),
    .rd_pc1   (rd_pc[1]),
    .rd_pc2   (rd_pc[2]),
    .rd_pc3   (rd_pc[3]),
    .rd_tgt0  (rd_tgt[0]),
    .rd_tgt1  (rd_tgt[1]),
    .rd_tgt2  (rd_tgt[2]),
    .rd_tgt3  (rd_tgt[3]),
    .hit      (hit),
    .hit_tgt  (hit_tgt),
    .hit_slot (hit_slot)
  );

  btb_next_pc i_next_pc (
    .fetch_pc      (fetch_pc),
    .miss_redirect (miss_redirect),
    .miss_pc       (miss_pc),
    .call_redirect (call_redirect),
    .call_tgt      (call_tgt),
    .hit           (hit),
    .hit_tgt       (hit_tgt),
    .next_pc       (next_pc),
    .takb          (takb)
  );

endmodule : fetch_btb

`default_nettype wire

// File: hw/btb_next_pc.sv
// fixed-priority next fetch address and taken flag
`timescale 1ns/1ps
`default_nettype none

`include "btb_cfg.svh"

module btb_next_pc
  import btb_pkg::*;
(
  input  wire pc_addr_t  fetch_pc,
  input  wire            miss_redirect,   // branch miss with highest priority
  input  wire pc_addr_t  miss_pc,
  input  wire            call_redirect,   // subroutine call
  input  wire pc_addr_t  call_tgt,
  input  wire            hit,             // taken hit from the banks
  input  wire pc_addr_t  hit_tgt,
  output pc_addr_t       next_pc,
  output logic           takb
);

  // ==============================
  // priority select
  // ==============================
  always_comb begin
    if (miss_redirect) begin
      next_pc = miss_pc;
      takb    = 1'b1;
    end else if (call_redirect) begin
      next_pc = call_tgt;
      takb    = 1'b1;
    end else if (hit) begin
      next_pc = hit_tgt;
      takb    = 1'b1;
    end else begin
      // fall through to the next four instructions
      next_pc = fetch_pc + pc_addr_t'(`BTB_FETCH_BYTES);
      takb    = 1'b0;
    end
  end

endmodule : btb_next_pc

`default_nettype wire

// File: hw/btb_hit_check.sv
// slot address generation, tag compare and first taken hit select
`timescale 1ns/1ps
`default_nettype none

`include "btb_cfg.svh"

module btb_hit_check
  import btb_pkg::*;
(
  input  wire pc_addr_t  fetch_pc,
  // bank outputs for each slot
  input  wire            rd_takb0,
  input  wire            rd_takb1,
  input  wire            rd_takb2,
  input  wire            rd_takb3,
  input  wire pc_addr_t  rd_pc0,
  input  wire pc_addr_t  rd_pc1,
  input  wire pc_addr_t  rd_pc2,
  input  wire pc_addr_t  rd_pc3,
  input  wire pc_addr_t  rd_tgt0,
  input  wire pc_addr_t  rd_tgt1,
  input  wire pc_addr_t  rd_tgt2,
  input  wire pc_addr_t  rd_tgt3,
  // result
  output logic           hit,
  output pc_addr_t       hit_tgt,
  output slot_t          hit_slot
);

  // ==============================
  // slot addresses
  // ==============================
  pc_addr_t   slot_pc1;   // fetch_pc + 5
  pc_addr_t   slot_pc2;   // fetch_pc + 10
  pc_addr_t   slot_pc3;   // fetch_pc + 15
  logic [3:0] slot_hit;   // per-slot taken and tag match

  assign slot_pc1 = fetch_pc + pc_addr_t'(`BTB_INSN_BYTES);
  assign slot_pc2 = fetch_pc + pc_addr_t'(2 * `BTB_INSN_BYTES);
  assign slot_pc3 = fetch_pc + pc_addr_t'(3 * `BTB_INSN_BYTES);

  // slot 0 sits at the fetch address itself
  assign slot_hit[0] = rd_takb0 && (rd_pc0 == fetch_pc);
  assign slot_hit[1] = rd_takb1 && (rd_pc1 == slot_pc1);
  assign slot_hit[2] = rd_takb2 && (rd_pc2 == slot_pc2);
  assign slot_hit[3] = rd_takb3 && (rd_pc3 == slot_pc3);

  assign hit = |slot_hit;

  // ==============================
  // lowest slot wins
  // ==============================
  always_comb begin
    hit_tgt  = '0;             // don't care when hit is low
    hit_slot = slot_t'(0);
    casez (slot_hit)
      4'b???1: begin
        hit_tgt  = rd_tgt0;
        hit_slot = slot_t'(0);
      end
      4'b??10: begin
        hit_tgt  = rd_tgt1;
        hit_slot = slot_t'(1);
      end
      4'b?100: begin
        hit_tgt  = rd_tgt2;
        hit_slot = slot_t'(2);
      end
      4'b1000: begin
        hit_tgt  = rd_tgt3;
        hit_slot = slot_t'(3);
      end
      default: ;               // no slot hit
    endcase
  end

endmodule : btb_hit_check

`default_nettype wire

// File: hw/btb_commit_stage.sv
// commit staging register for the four slots with the shared write index and enable
`timescale 1ns/1ps
`default_nettype none

`include "btb_cfg.svh"

module btb_commit_stage
  import btb_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  // one committed branch per slot
  input  wire pc_addr_t  commit_pc0,
  input  wire pc_addr_t  commit_pc1,
  input  wire pc_addr_t  commit_pc2,
  input  wire pc_addr_t  commit_pc3,
  input  wire pc_addr_t  commit_tgt0,
  input  wire pc_addr_t  commit_tgt1,
  input  wire pc_addr_t  commit_tgt2,
  input  wire pc_addr_t  commit_tgt3,
  input  wire            commit_takb0,
  input  wire            commit_takb1,
  input  wire            commit_takb2,
  input  wire            commit_takb3,
  // staged write into every bank
  output logic           wr_en,
  output btb_idx_t       wr_idx,
  output pc_addr_t       wr_pc0,
  output pc_addr_t       wr_pc1,
  output pc_addr_t       wr_pc2,
  output pc_addr_t       wr_pc3,
  output pc_addr_t       wr_tgt0,
  output pc_addr_t       wr_tgt1,
  output pc_addr_t       wr_tgt2,
  output pc_addr_t       wr_tgt3,
  output logic           wr_takb0,
  output logic           wr_takb1,
  output logic           wr_takb2,
  output logic           wr_takb3
);

  // any taken slot writes the whole row
  logic any_takb;

  assign any_takb = commit_takb0 | commit_takb1 | commit_takb2 | commit_takb3;

  // ==============================
  // one register stage
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en    <= 1'b0;
      wr_idx   <= '0;
      wr_pc0   <= '0;
      wr_pc1   <= '0;
      wr_pc2   <= '0;
      wr_pc3   <= '0;
      wr_tgt0  <= '0;
      wr_tgt1  <= '0;
      wr_tgt2  <= '0;
      wr_tgt3  <= '0;
      wr_takb0 <= 1'b0;
      wr_takb1 <= 1'b0;
      wr_takb2 <= 1'b0;
      wr_takb3 <= 1'b0;
    end else begin
      wr_en    <= any_takb;
      wr_idx   <= commit_pc0[`BTB_IDX_LO +: `BTB_IDX_W];  // row from slot 0 only
      wr_pc0   <= commit_pc0;
      wr_pc1   <= commit_pc1;
      wr_pc2   <= commit_pc2;
      wr_pc3   <= commit_pc3;
      wr_tgt0  <= commit_tgt0;
      wr_tgt1  <= commit_tgt1;
      wr_tgt2  <= commit_tgt2;
      wr_tgt3  <= commit_tgt3;
      wr_takb0 <= commit_takb0;     // a clear bit wipes that slot's entry
      wr_takb1 <= commit_takb1;
      wr_takb2 <= commit_takb2;
      wr_takb3 <= commit_takb3;
    end
  end

endmodule : btb_commit_stage

`default_nettype wire

// File: hw/btb_bank.sv
// one slot's btb entry ram with 1-cycle write and 2-cycle registered read
`timescale 1ns/1ps
`default_nettype none

`include "btb_cfg.svh"

module btb_bank
  import btb_pkg::*;
(
  input  wire            clk,
  // write port driven from the commit stage
  input  wire            wr_en,
  input  wire btb_idx_t  wr_idx,
  input  wire            wr_takb,
  input  wire pc_addr_t  wr_pc,
  input  wire pc_addr_t  wr_tgt,
  // read port indexed by the fetch address
  input  wire btb_idx_t  rd_idx,
  output logic           rd_takb,
  output pc_addr_t       rd_pc,
  output pc_addr_t       rd_tgt
);

  // entry fields kept in three parallel arrays
  logic     takb_mem [`BTB_DEPTH];   // taken bit
  pc_addr_t pc_mem   [`BTB_DEPTH];   // branch address used as the tag
  pc_addr_t tgt_mem  [`BTB_DEPTH];   // branch target

  btb_idx_t rd_idx_q;                // registered read address

  // empty table at power up so no stale taken bits
  initial begin
    for (int i = 0; i < `BTB_DEPTH; i++) begin
      takb_mem[i] = 1'b0;
      pc_mem[i]   = '0;
      tgt_mem[i]  = '0;
    end
  end

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      takb_mem[wr_idx] <= wr_takb;   // not-taken slots clear their entry
      pc_mem[wr_idx]   <= wr_pc;
      tgt_mem[wr_idx]  <= wr_tgt;
    end
  end

  // ==============================
  // read port with address reg then data reg
  // ==============================
  always_ff @(posedge clk) begin
    rd_idx_q <= rd_idx;                // first edge
    rd_takb  <= takb_mem[rd_idx_q];    // second edge
    rd_pc    <= pc_mem[rd_idx_q];
    rd_tgt   <= tgt_mem[rd_idx_q];
  end

endmodule : btb_bank

`default_nettype wire

// File: hw/btb_pkg.sv
// btb shared types for the fetch address, bank index and slot number
`default_nettype none

`include "btb_cfg.svh"

package btb_pkg;

  // ==============================
  // address types
  // ==============================
  typedef logic [`BTB_PC_W-1:0]  pc_addr_t;   // fetch pc, branch pc or target

  typedef logic [`BTB_IDX_W-1:0] btb_idx_t;   // row in each bank

  // ==============================
  // slot number
  // ==============================
  typedef logic [1:0]            slot_t;      // which of the four fetch slots

endpackage : btb_pkg

`default_nettype wire

// File: include/btb_cfg.svh
// btb address width, bank depth, index position, instruction size and slot count macros
`ifndef BTB_CFG_SVH
`define BTB_CFG_SVH

// ==============================
// address and index
// ==============================
`define BTB_PC_W        32                     // fetch / target address width
`define BTB_IDX_W       10                     // bank index width
`define BTB_DEPTH       (1 << `BTB_IDX_W)      // 1024 entries per bank
`define BTB_IDX_LO      12                     // lowest pc bit used for the index

// ==============================
// fetch group shape
// ==============================
`define BTB_INSN_BYTES  5                      // fixed instruction length
`define BTB_SLOTS       4                      // instructions per fetch group

// 20-byte sequential advance when nothing redirects
`define BTB_FETCH_BYTES (`BTB_SLOTS * `BTB_INSN_BYTES)

`endif
